// ==== Makefile ====
# Verilator build and run for the write-line generator testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_wr_gen -f compile.f

# the run passes only when the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/Vtb_wr_gen 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+rtl
rtl/wr_gen_cfg_pkg.sv
rtl/wr_gen_data_pkg.sv
rtl/wr_gen_cfg_regs.sv
rtl/wr_gen_sequencer.sv
rtl/wr_gen_addr_pipe.sv
rtl/wr_gen_fifo.sv
rtl/wr_gen_line_issue.sv
rtl/wr_gen_top.sv
testbench/tb_wr_gen.sv

// ==== rtl/wr_gen_addr_pipe.sv ====
/*
  address pipeline, stages two and three
  builds base plus N times increment with a running offset and
  cuts the pattern to the configured size
*/
`timescale 1ns/10ps

module wr_gen_addr_pipe
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     i_item_valid,
  input  wr_gen_data_pkg::index_t   i_item_index,
  input  wr_gen_data_pkg::pattern_t i_item_pattern,
  input  wr_gen_data_pkg::addr_t    i_base,
  input  wr_gen_cfg_pkg::incr_t     i_incr,
  input  wr_gen_cfg_pkg::psize_t    i_psize,
  output logic                     o_push,
  output wr_gen_data_pkg::addr_t    o_addr,
  output wr_gen_data_pkg::pattern_t o_pattern
);

  // stage two registers
  logic                      s2_valid;
  wr_gen_data_pkg::addr_t    s2_offset;
  wr_gen_data_pkg::pattern_t s2_pattern;

  // pattern after the size cut, ahead of the stage two register
  wr_gen_data_pkg::pattern_t cut_pattern;

  // lower bytes of the pattern are kept, any unsupported size gives zero
  always_comb
  begin
    case (i_psize)
      3'd1:    cut_pattern = {24'h0, i_item_pattern[7:0]};
      3'd2:    cut_pattern = {16'h0, i_item_pattern[15:0]};
      3'd4:    cut_pattern = i_item_pattern;
      default: cut_pattern = '0;
    endcase
  end

  // valid bits move one stage per cycle with no stall
  // the FIFO threshold keeps enough room for everything in flight
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      s2_valid <= 1'b0;
      o_push   <= 1'b0;
    end
    else
    begin
      s2_valid <= i_item_valid;
      o_push   <= s2_valid;
    end
  end

  // items arrive with N counting up by one from 0,
  // so an accumulated increment replaces the multiply
  always_ff @(posedge clk)
  begin
    if (i_item_valid)
    begin
      if (i_item_index == '0)
        s2_offset <= '0;
      else
        s2_offset <= s2_offset + wr_gen_data_pkg::addr_t'(i_incr);
      s2_pattern <= cut_pattern;
    end
  end

  // stage three adds the base that the sequencer holds for the whole run
  always_ff @(posedge clk)
  begin
    if (s2_valid)
    begin
      o_addr    <= i_base + s2_offset;
      o_pattern <= s2_pattern;
    end
  end

endmodule

// ==== rtl/wr_gen_cfg_pkg.sv ====
/*
  write-line generator configuration types
  register access and the values held by the register file
*/
`include "wr_gen_defs.svh"

package wr_gen_cfg_pkg;

  // register offset carried with a configuration write strobe
  typedef logic [2:0] cfg_addr_t;

  // one register data word
  typedef logic [31:0] cfg_data_t;

  // address step between two consecutive writes
  typedef logic [31:0] incr_t;

  // one bit per line byte, written as two data words
  typedef logic [`WG_LINE_BYTES-1:0] byte_mask_t;

  // pattern size in bytes, only 1, 2 and 4 give a non-zero pattern
  typedef logic [2:0] psize_t;

  // number of writes in one run
  typedef logic [`WG_CNT_W-1:0] wcount_t;

endpackage

// ==== rtl/wr_gen_cfg_regs.sv ====
/*
  configuration register file
  written by single-cycle strobes, holds increment, byte mask,
  pattern size and write count, locked while a run is in progress
*/
`timescale 1ns/10ps
`include "wr_gen_defs.svh"

module wr_gen_cfg_regs
(
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      i_cfg_wr,
  input  wr_gen_cfg_pkg::cfg_addr_t i_cfg_addr,
  input  wr_gen_cfg_pkg::cfg_data_t i_cfg_data,
  input  logic                      i_busy,
  output wr_gen_cfg_pkg::incr_t      o_incr,
  output wr_gen_cfg_pkg::byte_mask_t o_byte_mask,
  output wr_gen_cfg_pkg::psize_t     o_psize,
  output wr_gen_cfg_pkg::wcount_t    o_wcount
);

  // the byte mask is kept as two register words
  wr_gen_cfg_pkg::cfg_data_t mask_lo;
  wr_gen_cfg_pkg::cfg_data_t mask_hi;

  // writes are dropped while busy so a run sees one stable configuration
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      o_incr   <= '0;
      mask_lo  <= '0;
      mask_hi  <= '0;
      o_psize  <= '0;
      o_wcount <= '0;
    end
    else if (i_cfg_wr && !i_busy)
    begin
      case (i_cfg_addr)
        `WG_REG_INCR:    o_incr   <= i_cfg_data;
        `WG_REG_MASK_LO: mask_lo  <= i_cfg_data;
        `WG_REG_MASK_HI: mask_hi  <= i_cfg_data;
        // only the low bits of the size and count words are kept
        `WG_REG_PSIZE:   o_psize  <= i_cfg_data[2:0];
        `WG_REG_COUNT:   o_wcount <= i_cfg_data[`WG_CNT_W-1:0];
        // unmapped offsets are ignored
        default:         o_incr   <= o_incr;
      endcase
    end
  end

  // high word covers line bytes 32 to 63
  assign o_byte_mask = {mask_hi, mask_lo};

endmodule

// ==== rtl/wr_gen_data_pkg.sv ====
/*
  write-line generator datapath types
  addresses, patterns, line data and the sequencer states
*/
`include "wr_gen_defs.svh"

package wr_gen_data_pkg;

  // write address, wider than one word
  typedef logic [`WG_ADDR_W-1:0] addr_t;

  // pattern value, stepped by one for every write
  typedef logic [`WG_PAT_W-1:0] pattern_t;

  // write index N inside a run
  typedef logic [`WG_CNT_W-1:0] index_t;

  // full cache line of write data
  typedef logic [`WG_LINE_BYTES*8-1:0] line_t;

  // sequencer states
  // RUN emits items, DRAIN waits for the remaining lines to be accepted
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2,
    DONE  = 2'd3
  } seq_state_t;

endpackage

// ==== rtl/wr_gen_defs.svh ====
/*
  write-line generator global definitions
  widths, FIFO sizing and the configuration register map
*/
`ifndef WR_GEN_DEFS_SVH
`define WR_GEN_DEFS_SVH

// write address width in bits
`define WG_ADDR_W 52
// pattern register width in bits
`define WG_PAT_W 32
// bytes per cache line, one strobe bit each
`define WG_LINE_BYTES 64
// width of the write count and of the write index
`define WG_CNT_W 9

// FIFO between the address pipeline and the issue stage
`define WG_FIFO_DEPTH 16
// occupancy at which the sequencer stops emitting items
`define WG_FIFO_THRESH 10

// configuration register offsets
`define WG_REG_INCR 3'd0
`define WG_REG_MASK_LO 3'd1
`define WG_REG_MASK_HI 3'd2
`define WG_REG_PSIZE 3'd3
`define WG_REG_COUNT 3'd4

`endif

// ==== rtl/wr_gen_fifo.sv ====
/*
  synchronous FIFO for address and pattern entries
  circular buffer with an occupancy count and a threshold flag
  that throttles the sequencer
*/
`timescale 1ns/10ps
`include "wr_gen_defs.svh"

module wr_gen_fifo
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     i_push,
  input  wr_gen_data_pkg::addr_t    i_push_addr,
  input  wr_gen_data_pkg::pattern_t i_push_pattern,
  input  logic                     i_pop,
  output wr_gen_data_pkg::addr_t    o_head_addr,
  output wr_gen_data_pkg::pattern_t o_head_pattern,
  output logic                     o_empty,
  output logic                     o_thresh
);

  localparam int PTR_W = $clog2(`WG_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  wr_gen_data_pkg::addr_t    mem_addr [`WG_FIFO_DEPTH];
  wr_gen_data_pkg::pattern_t mem_pat  [`WG_FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  // a pop on an empty FIFO is dropped
  assign do_pop = i_pop && !o_empty;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap on their own since the depth is a power of two
      if (i_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({i_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry storage, the threshold keeps pushes away from a full buffer
  always_ff @(posedge clk)
  begin
    if (i_push)
    begin
      mem_addr[wr_ptr] <= i_push_addr;
      mem_pat[wr_ptr]  <= i_push_pattern;
    end
  end

  // head is read straight from storage, a push shows up one cycle later
  assign o_head_addr    = mem_addr[rd_ptr];
  assign o_head_pattern = mem_pat[rd_ptr];
  assign o_empty        = (count == '0);
  assign o_thresh       = (count >= CNT_W'(`WG_FIFO_THRESH));

endmodule

// ==== rtl/wr_gen_line_issue.sv ====
/*
  line issue stage
  replicates the pattern over the line under the byte mask and holds
  one write request until the receiver accepts it
*/
`timescale 1ns/10ps
`include "wr_gen_defs.svh"

module wr_gen_line_issue
(
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      i_fifo_empty,
  input  wr_gen_data_pkg::addr_t     i_head_addr,
  input  wr_gen_data_pkg::pattern_t  i_head_pattern,
  input  wr_gen_cfg_pkg::byte_mask_t i_byte_mask,
  input  wr_gen_cfg_pkg::psize_t     i_psize,
  input  logic                      i_wr_ready,
  output logic                      o_pop,
  output logic                      o_line_sent,
  output logic                      o_wr_valid,
  output wr_gen_data_pkg::addr_t     o_wr_addr,
  output wr_gen_data_pkg::line_t     o_wr_data,
  output wr_gen_cfg_pkg::byte_mask_t o_wr_strb
);

  wr_gen_data_pkg::line_t line_next;
  logic [7:0]             pat_byte;

  // byte i of the line takes byte (i modulo size) of the pattern
  always_comb
  begin
    line_next = '0;
    pat_byte  = 8'h00;
    for (int i = 0; i < `WG_LINE_BYTES; i++)
    begin
      case (i_psize)
        3'd1:    pat_byte = i_head_pattern[7:0];
        3'd2:    pat_byte = i_head_pattern[8*(i%2) +: 8];
        3'd4:    pat_byte = i_head_pattern[8*(i%4) +: 8];
        default: pat_byte = 8'h00;
      endcase
      line_next[8*i +: 8] = i_byte_mask[i] ? pat_byte : 8'h00;
    end
  end

  // take the next entry when the holding register is free or being accepted
  assign o_pop       = !i_fifo_empty && (!o_wr_valid || i_wr_ready);
  assign o_line_sent = o_wr_valid && i_wr_ready;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      o_wr_valid <= 1'b0;
    else if (o_pop)
      o_wr_valid <= 1'b1;
    else if (i_wr_ready)
      o_wr_valid <= 1'b0;
  end

  // payload only changes on a pop, so it is stable while valid waits
  always_ff @(posedge clk)
  begin
    if (o_pop)
    begin
      o_wr_addr <= i_head_addr;
      o_wr_data <= line_next;
      o_wr_strb <= i_byte_mask;
    end
  end

endmodule

// ==== rtl/wr_gen_sequencer.sv ====
/*
  write sequencer
  start/busy state machine, pipeline stage one with the write index
  and pattern counters, and completion counting from accepted lines
*/
`timescale 1ns/10ps

module wr_gen_sequencer
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     i_start,
  input  wr_gen_data_pkg::addr_t    i_base_addr,
  input  wr_gen_data_pkg::pattern_t i_start_pattern,
  input  wr_gen_cfg_pkg::wcount_t   i_wcount,
  input  logic                     i_fifo_thresh,
  input  logic                     i_line_sent,
  output logic                     o_busy,
  output logic                     o_item_valid,
  output wr_gen_data_pkg::index_t   o_item_index,
  output wr_gen_data_pkg::pattern_t o_item_pattern,
  output wr_gen_data_pkg::addr_t    o_base
);

  wr_gen_data_pkg::seq_state_t state;
  wr_gen_data_pkg::seq_state_t next_state;

  // index and pattern of the next item to emit
  wr_gen_data_pkg::index_t   next_n;
  wr_gen_data_pkg::pattern_t next_pat;
  // lines accepted at the output during this run
  wr_gen_cfg_pkg::wcount_t   sent_cnt;
  logic                      emit;

  // items stop while the FIFO is at its threshold or all have been issued
  assign emit = (state == wr_gen_data_pkg::RUN) && !i_fifo_thresh && (next_n < i_wcount);

  always_comb
  begin
    next_state = state;
    case (state)
      wr_gen_data_pkg::IDLE:
      begin
        // an empty run skips straight to completion
        if (i_start)
          next_state = (i_wcount == '0) ? wr_gen_data_pkg::DONE : wr_gen_data_pkg::RUN;
      end
      wr_gen_data_pkg::RUN:
      begin
        if (next_n == i_wcount)
          next_state = wr_gen_data_pkg::DRAIN;
      end
      wr_gen_data_pkg::DRAIN:
      begin
        if (sent_cnt == i_wcount)
          next_state = wr_gen_data_pkg::DONE;
      end
      default:
        next_state = wr_gen_data_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state        <= wr_gen_data_pkg::IDLE;
      o_busy       <= 1'b0;
      o_item_valid <= 1'b0;
      next_n       <= '0;
      sent_cnt     <= '0;
    end
    else
    begin
      state        <= next_state;
      o_item_valid <= emit;
      // busy covers every state but IDLE and drops the cycle after DONE
      if (state == wr_gen_data_pkg::IDLE && i_start)
        o_busy <= 1'b1;
      else if (state == wr_gen_data_pkg::DONE)
        o_busy <= 1'b0;
      if (state == wr_gen_data_pkg::IDLE && i_start)
      begin
        next_n   <= '0;
        sent_cnt <= '0;
      end
      else
      begin
        if (emit)
          next_n <= next_n + 1'b1;
        if (i_line_sent)
          sent_cnt <= sent_cnt + 1'b1;
      end
    end
  end

  // base and pattern are captured once per run, item payload follows emit
  always_ff @(posedge clk)
  begin
    if (state == wr_gen_data_pkg::IDLE && i_start)
    begin
      o_base   <= i_base_addr;
      next_pat <= i_start_pattern;
    end
    else if (emit)
    begin
      next_pat <= next_pat + 1'b1;
    end
    if (emit)
    begin
      o_item_index   <= next_n;
      o_item_pattern <= next_pat;
    end
  end

endmodule

// ==== rtl/wr_gen_top.sv ====
/*
  write-line generator top level
  configuration registers, sequencer, address pipeline, FIFO and issue stage
*/
`timescale 1ns/10ps

module wr_gen_top
(
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      i_cfg_wr,
  input  wr_gen_cfg_pkg::cfg_addr_t  i_cfg_addr,
  input  wr_gen_cfg_pkg::cfg_data_t  i_cfg_data,
  input  logic                      i_start,
  input  wr_gen_data_pkg::addr_t     i_base_addr,
  input  wr_gen_data_pkg::pattern_t  i_start_pattern,
  input  logic                      i_wr_ready,
  output logic                      o_busy,
  output logic                      o_wr_valid,
  output wr_gen_data_pkg::addr_t     o_wr_addr,
  output wr_gen_data_pkg::line_t     o_wr_data,
  output wr_gen_cfg_pkg::byte_mask_t o_wr_strb
);

  // configuration values
  wr_gen_cfg_pkg::incr_t      incr;
  wr_gen_cfg_pkg::byte_mask_t byte_mask;
  wr_gen_cfg_pkg::psize_t     psize;
  wr_gen_cfg_pkg::wcount_t    wcount;

  // sequencer to address pipe
  logic                      item_valid;
  wr_gen_data_pkg::index_t   item_index;
  wr_gen_data_pkg::pattern_t item_pattern;
  wr_gen_data_pkg::addr_t    base;

  // address pipe to FIFO
  logic                      push;
  wr_gen_data_pkg::addr_t    push_addr;
  wr_gen_data_pkg::pattern_t push_pattern;

  // FIFO, issue stage and completion feedback
  wr_gen_data_pkg::addr_t    head_addr;
  wr_gen_data_pkg::pattern_t head_pattern;
  logic                      fifo_empty;
  logic                      fifo_thresh;
  logic                      pop;
  logic                      line_sent;

  wr_gen_cfg_regs u_cfg_regs
  (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_cfg_wr    (i_cfg_wr),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_data  (i_cfg_data),
    .i_busy      (o_busy),
    .o_incr      (incr),
    .o_byte_mask (byte_mask),
    .o_psize     (psize),
    .o_wcount    (wcount)
  );

  wr_gen_sequencer u_sequencer
  (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_start         (i_start),
    .i_base_addr     (i_base_addr),
    .i_start_pattern (i_start_pattern),
    .i_wcount        (wcount),
    .i_fifo_thresh   (fifo_thresh),
    .i_line_sent     (line_sent),
    .o_busy          (o_busy),
    .o_item_valid    (item_valid),
    .o_item_index    (item_index),
    .o_item_pattern  (item_pattern),
    .o_base          (base)
  );

  wr_gen_addr_pipe u_addr_pipe
  (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_item_valid   (item_valid),
    .i_item_index   (item_index),
    .i_item_pattern (item_pattern),
    .i_base         (base),
    .i_incr         (incr),
    .i_psize        (psize),
    .o_push         (push),
    .o_addr         (push_addr),
    .o_pattern      (push_pattern)
  );

  wr_gen_fifo u_fifo
  (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_push         (push),
    .i_push_addr    (push_addr),
    .i_push_pattern (push_pattern),
    .i_pop          (pop),
    .o_head_addr    (head_addr),
    .o_head_pattern (head_pattern),
    .o_empty        (fifo_empty),
    .o_thresh       (fifo_thresh)
  );

  wr_gen_line_issue u_line_issue
  (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_fifo_empty   (fifo_empty),
    .i_head_addr    (head_addr),
    .i_head_pattern (head_pattern),
    .i_byte_mask    (byte_mask),
    .i_psize        (psize),
    .i_wr_ready     (i_wr_ready),
    .o_pop          (pop),
    .o_line_sent    (line_sent),
    .o_wr_valid     (o_wr_valid),
    .o_wr_addr      (o_wr_addr),
    .o_wr_data      (o_wr_data),
    .o_wr_strb      (o_wr_strb)
  );

endmodule

// ==== testbench/tb_wr_gen.sv ====
/*
  testbench for the write-line generator
  configures the register file, starts runs and checks every accepted
  line against a reference model of the write rule
*/
`timescale 1ns/10ps
`include "wr_gen_defs.svh"

module tb_wr_gen;

  localparam int CLK_PERIOD = 20;
  // the total of writes over all runs sizes the watchdog
  localparam int TOTAL_WRITES = 5 + 3 * 8 + 40 + 2 * 12;
  localparam int WATCHDOG_CYCLES = TOTAL_WRITES * 40 + 500;

  logic                       clk;
  logic                       reset_n;
  logic                       i_cfg_wr;
  wr_gen_cfg_pkg::cfg_addr_t  i_cfg_addr;
  wr_gen_cfg_pkg::cfg_data_t  i_cfg_data;
  logic                       i_start;
  wr_gen_data_pkg::addr_t     i_base_addr;
  wr_gen_data_pkg::pattern_t  i_start_pattern;
  logic                       i_wr_ready;
  logic                       o_busy;
  logic                       o_wr_valid;
  wr_gen_data_pkg::addr_t     o_wr_addr;
  wr_gen_data_pkg::line_t     o_wr_data;
  wr_gen_cfg_pkg::byte_mask_t o_wr_strb;

  // configuration the current run should use, and the run's start values
  wr_gen_cfg_pkg::incr_t      cfg_incr;
  wr_gen_cfg_pkg::byte_mask_t cfg_mask;
  wr_gen_cfg_pkg::psize_t     cfg_psize;
  wr_gen_cfg_pkg::wcount_t    cfg_count;
  wr_gen_data_pkg::addr_t     run_base;
  wr_gen_data_pkg::pattern_t  run_pat;
  wr_gen_cfg_pkg::wcount_t    exp_count;
  int unsigned                lines_seen;
  string                      test_name;
  logic                       random_ready;
  logic [31:0]                lcg_state;
  // set once the first start strobe has been driven
  logic                       run_started;

  wr_gen_top DUT
  (
    .clk             (clk),
    .reset_n         (reset_n),
    .i_cfg_wr        (i_cfg_wr),
    .i_cfg_addr      (i_cfg_addr),
    .i_cfg_data      (i_cfg_data),
    .i_start         (i_start),
    .i_base_addr     (i_base_addr),
    .i_start_pattern (i_start_pattern),
    .i_wr_ready      (i_wr_ready),
    .o_busy          (o_busy),
    .o_wr_valid      (o_wr_valid),
    .o_wr_addr       (o_wr_addr),
    .o_wr_data       (o_wr_data),
    .o_wr_strb       (o_wr_strb)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // standard 32-bit LCG step
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // write N goes to base + N * increment and its data is the sized pattern
  // start + N repeated over the line and cleared where the mask is clear
  function automatic void expected_write(input int unsigned n,
                                         output wr_gen_data_pkg::addr_t addr,
                                         output wr_gen_data_pkg::line_t data,
                                         output wr_gen_cfg_pkg::byte_mask_t strb);
    wr_gen_data_pkg::pattern_t pat;
    int unsigned               size;
    int                        i;
    pat = run_pat + wr_gen_data_pkg::pattern_t'(n);
    case (cfg_psize)
      3'd1:    size = 1;
      3'd2:    size = 2;
      3'd4:    size = 4;
      default: size = 0;
    endcase
    addr = run_base + wr_gen_data_pkg::addr_t'(n) * wr_gen_data_pkg::addr_t'(cfg_incr);
    strb = cfg_mask;
    data = '0;
    // an illegal size leaves the whole line at zero
    for (i = 0; i < `WG_LINE_BYTES; i++)
    begin
      if (size != 0 && cfg_mask[i])
        data[8*i +: 8] = 8'(pat >> (8 * (i % size)));
    end
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_addr(input string name, input wr_gen_data_pkg::addr_t exp,
                            input wr_gen_data_pkg::addr_t act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s addr: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_line(input string name, input wr_gen_data_pkg::line_t exp,
                            input wr_gen_data_pkg::line_t act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s data: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_strb(input string name, input wr_gen_cfg_pkg::byte_mask_t exp,
                            input wr_gen_cfg_pkg::byte_mask_t act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s strb: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input wr_gen_cfg_pkg::wcount_t exp,
                             input wr_gen_cfg_pkg::wcount_t act);
    if (act !== exp)
      report_failure($sformatf("MISMATCH %s line count: expected %0d, actual %0d",
                               name, exp, act));
  endtask

  // one register write strobe with inputs changed 2 ns after the edge
  task automatic write_reg(input wr_gen_cfg_pkg::cfg_addr_t addr,
                           input wr_gen_cfg_pkg::cfg_data_t data);
    @(posedge clk);
    #2;
    i_cfg_wr   = 1'b1;
    i_cfg_addr = addr;
    i_cfg_data = data;
    @(posedge clk);
    #2;
    i_cfg_wr = 1'b0;
  endtask

  // writes all registers and records the values for the reference model
  task automatic set_config(input wr_gen_cfg_pkg::incr_t incr,
                            input wr_gen_cfg_pkg::byte_mask_t mask,
                            input wr_gen_cfg_pkg::psize_t psize,
                            input wr_gen_cfg_pkg::wcount_t count);
    write_reg(`WG_REG_INCR, incr);
    write_reg(`WG_REG_MASK_LO, mask[31:0]);
    write_reg(`WG_REG_MASK_HI, mask[63:32]);
    write_reg(`WG_REG_PSIZE, wr_gen_cfg_pkg::cfg_data_t'(psize));
    write_reg(`WG_REG_COUNT, wr_gen_cfg_pkg::cfg_data_t'(count));
    cfg_incr  = incr;
    cfg_mask  = mask;
    cfg_psize = psize;
    cfg_count = count;
  endtask

  task automatic start_run(input wr_gen_data_pkg::addr_t base,
                           input wr_gen_data_pkg::pattern_t pat);
    run_base   = base;
    run_pat    = pat;
    exp_count  = cfg_count;
    lines_seen = 0;
    @(posedge clk);
    #2;
    run_started     = 1'b1;
    i_start         = 1'b1;
    i_base_addr     = base;
    i_start_pattern = pat;
    @(posedge clk);
    #2;
    i_start = 1'b0;
    // the start was taken on the edge just passed
    if (o_busy !== 1'b1)
      report_failure($sformatf("%s: o_busy did not rise the cycle after start", test_name));
  endtask

  // waits for busy to fall and compares the number of accepted lines
  task automatic wait_run_end();
    do
      @(negedge clk);
    while (o_busy !== 1'b0);
    check_count(test_name, exp_count, wr_gen_cfg_pkg::wcount_t'(lines_seen));
  endtask

  // ready is held high or follows one LCG bit and changes 2 ns after each edge
  initial
  begin
    forever
    begin
      @(posedge clk);
      #2;
      if (random_ready)
      begin
        lcg_state  = lcg_next(lcg_state);
        i_wr_ready = lcg_state[30];
      end
      else
      begin
        i_wr_ready = 1'b1;
      end
    end
  end

  // a line counts as accepted when valid and ready are both high mid-cycle
  initial
  begin
    wr_gen_data_pkg::addr_t     exp_addr;
    wr_gen_data_pkg::line_t     exp_data;
    wr_gen_cfg_pkg::byte_mask_t exp_strb;
    string                      name;
    forever
    begin
      @(negedge clk);
      // nothing may happen between reset and the first start
      if (reset_n && !run_started && (o_busy !== 1'b0 || o_wr_valid !== 1'b0))
        report_failure("o_busy or o_wr_valid went high before the first start");
      if (reset_n && o_wr_valid === 1'b1 && i_wr_ready === 1'b1)
      begin
        if (o_busy !== 1'b1)
          report_failure($sformatf("%s: line accepted while o_busy is low", test_name));
        name = $sformatf("%s line %0d", test_name, lines_seen);
        expected_write(lines_seen, exp_addr, exp_data, exp_strb);
        check_addr(name, exp_addr, o_wr_addr);
        check_line(name, exp_data, o_wr_data);
        check_strb(name, exp_strb, o_wr_strb);
        lines_seen++;
      end
    end
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog expired before all tests completed");
  end

  initial
  begin
    reset_n         = 1'b0;
    i_cfg_wr        = 1'b0;
    i_cfg_addr      = '0;
    i_cfg_data      = '0;
    i_start         = 1'b0;
    i_base_addr     = '0;
    i_start_pattern = '0;
    i_wr_ready      = 1'b0;
    random_ready    = 1'b0;
    run_started     = 1'b0;
    lcg_state       = 32'hed77_4f65;
    lines_seen      = 0;
    exp_count       = '0;
    test_name       = "reset_idle";
    repeat (10) @(posedge clk);
    #2;
    reset_n = 1'b1;

    // idle cycles after reset before the first configuration
    repeat (8) @(negedge clk);

    test_name = "size4_full";
    set_config(32'h0000_0040, {64{1'b1}}, 3'd4, 9'd5);
    start_run(52'h0_1234_5678_9000, 32'hA5A5_0000);
    wait_run_end();

    // the pattern wraps through zero here
    test_name = "size1_sparse";
    set_config(32'h0000_1000, 64'h8000_0001_00F0_0F01, 3'd1, 9'd8);
    start_run(52'h0_0000_0010_0000, 32'hFFFF_FFFC);
    wait_run_end();

    // the address wraps past the top of the 52-bit space
    test_name = "size2_sparse";
    set_config(32'h0000_1000, 64'h5555_0000_AAAA_3C3C, 3'd2, 9'd8);
    start_run(52'hF_FFFF_FFFF_C000, 32'h1234_ABCD);
    wait_run_end();

    test_name = "size0_zero";
    set_config(32'h0000_0100, 64'hFFFF_0000_FFFF_0000, 3'd0, 9'd8);
    start_run(52'h0_0000_0000_0000, 32'hDEAD_BEEF);
    wait_run_end();

    // random ready fills the FIFO so the threshold throttles the sequencer
    test_name    = "random_ready_40";
    random_ready = 1'b1;
    set_config(32'hFFFF_FFC0, 64'hF0F0_FFFF_0000_FF0F, 3'd4, 9'd40);
    start_run(52'h8_0000_0000_0000, 32'h0000_0100);
    wait_run_end();

    // these writes land while busy and must not reach either run
    test_name = "locked_cfg";
    set_config(32'h0000_0080, 64'hFFFF_FFFF_0000_FFFF, 3'd2, 9'd12);
    start_run(52'h0_0000_ABCD_0000, 32'h0102_0304);
    write_reg(`WG_REG_PSIZE, 32'd1);
    write_reg(`WG_REG_INCR, 32'h0000_0004);
    write_reg(`WG_REG_COUNT, 32'd3);
    write_reg(`WG_REG_MASK_LO, 32'h0000_0000);
    if (o_busy !== 1'b1)
      report_failure("run ended before the writes made while busy were issued");
    wait_run_end();

    test_name = "locked_cfg_next";
    start_run(52'h0_0000_0000_4000, 32'h7FFF_FFF8);
    wait_run_end();

    // an empty run only pulses busy
    test_name = "empty_run";
    set_config(32'h0000_0040, {64{1'b1}}, 3'd4, 9'd0);
    start_run(52'h0_0000_0000_1000, 32'h0000_0001);
    wait_run_end();

    $display("All tests passed!");
    $finish;
  end

endmodule
